/* bench/rtype_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rtype_checker (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    // expected entry, taken with the instruction it belongs to
    input  logic                            exp_push,
    input  logic [mips_pkg::reg_addr_w-1:0] exp_reg,
    input  logic [mips_pkg::xlen-1:0]       exp_data,
    // dut outputs under watch
    input  logic                            wb_valid,
    input  logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    input  logic [mips_pkg::xlen-1:0]       wb_data,
    input  logic [mips_pkg::xlen-1:0]       regfile_v0,
    output int                              error_count,
    output int                              retired_count,
    output int                              pending_count
);
    import mips_pkg::*;

    logic [reg_addr_w-1:0] reg_q [$];
    logic [xlen-1:0]       data_q [$];
    // v0 as it should be after all retired writes
    logic [xlen-1:0]       model_v0;
    logic [reg_addr_w-1:0] want_reg;
    logic [xlen-1:0]       want_data;

    // pre-edge values, a write-back retires on an enabled edge
    always @(posedge r_clk) begin
        if (reset) begin
            reg_q.delete();
            data_q.delete();
            model_v0      = '0;
            error_count   = 0;
            retired_count = 0;
        end else if (r_clk_enable) begin
            if (wb_valid) begin
                retired_count = retired_count + 1;
                if (reg_q.size() == 0) begin
                    $display("FAILED %0t: unexpected write-back reg %0d data %h",
                             $time, wb_reg, wb_data);
                    error_count = error_count + 1;
                end else begin
                    want_reg  = reg_q.pop_front();
                    want_data = data_q.pop_front();
                    if ((wb_reg !== want_reg) || (wb_data !== want_data)) begin
                        $display("FAILED %0t: write-back reg %0d data %h, expected reg %0d data %h",
                                 $time, wb_reg, wb_data, want_reg, want_data);
                        error_count = error_count + 1;
                    end
                    // every earlier write is in the file by now
                    if (regfile_v0 !== model_v0) begin
                        $display("FAILED %0t: regfile_v0 %h, expected %h",
                                 $time, regfile_v0, model_v0);
                        error_count = error_count + 1;
                    end
                    if (want_reg == reg_addr_w'(v0_index)) begin
                        model_v0 = want_data;
                    end
                end
            end
            // push after pop, the new entry is younger
            if (exp_push) begin
                reg_q.push_back(exp_reg);
                data_q.push_back(exp_data);
            end
        end
        pending_count = reg_q.size();
    end

endmodule

`default_nettype wire

/* bench/rtype_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rtype_core_tb;
    import mips_pkg::*;

    localparam int vec_count      = 25;
    localparam int timeout_cycles = 4 * vec_count + 50;

    logic                  r_clk;
    logic                  reset;
    logic                  r_clk_enable;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_reg;
    logic [xlen-1:0]       wb_data;
    logic [xlen-1:0]       regfile_v0;

    // expected write-back for the instruction on the bus
    logic                  exp_push;
    logic [reg_addr_w-1:0] exp_reg;
    logic [xlen-1:0]       exp_data;
    int                    error_count;
    int                    retired_count;
    int                    pending_count;

    // instr[75:44], write flag[43:40], reg[39:32], data[31:0]
    logic [75:0]           vec_mem [0:vec_count-1];
    integer                seed;
    int                    cycle_count = 0;
    int                    write_count;
    int                    end_errors;
    logic [xlen-1:0]       final_v0;

    rtype_core u_rtype_core (
        .r_clk, .reset, .r_clk_enable, .instr_valid, .instr,
        .wb_valid, .wb_reg, .wb_data, .regfile_v0
    );

    rtype_checker u_checker (
        .r_clk, .reset, .r_clk_enable,
        .exp_push, .exp_reg, .exp_data,
        .wb_valid, .wb_reg, .wb_data, .regfile_v0,
        .error_count, .retired_count, .pending_count
    );

    // 4 ns period
    initial r_clk = 1'b0;
    always #2 r_clk = ~r_clk;

    // enable low about one cycle in four
    function automatic logic pick_enable();
        pick_enable = (($random(seed) & 3) != 0);
    endfunction

    // hold one instruction until an enabled edge takes it
    task automatic issue_one(input logic [75:0] entry);
        logic en;
        en = 1'b0;
        while (!en) begin
            @(negedge r_clk);
            en           = pick_enable();
            r_clk_enable = en;
            instr_valid  = 1'b1;
            instr        = entry[75:44];
            exp_push     = entry[40];
            exp_reg      = entry[36:32];
            exp_data     = entry[31:0];
        end
    endtask

    initial begin
        seed         = 6500;
        reset        = 1'b1;
        r_clk_enable = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        exp_push     = 1'b0;
        exp_reg      = '0;
        exp_data     = '0;
        end_errors   = 0;
        write_count  = 0;
        final_v0     = '0;
        $readmemh("bench/rtype_vectors.txt", vec_mem);
        // write count and last v0 value straight from the vectors
        for (int i = 0; i < vec_count; i++) begin
            if (vec_mem[i][40]) begin
                write_count = write_count + 1;
                if (vec_mem[i][36:32] == reg_addr_w'(v0_index)) begin
                    final_v0 = vec_mem[i][31:0];
                end
            end
        end
        repeat (2) @(negedge r_clk);
        reset = 1'b0;
        for (int i = 0; i < vec_count; i++) begin
            issue_one(vec_mem[i]);
        end
        // drain, enable gaps continue
        while (retired_count < write_count) begin
            @(negedge r_clk);
            r_clk_enable = pick_enable();
            instr_valid  = 1'b0;
            exp_push     = 1'b0;
        end
        // a few idle edges to catch stray pulses
        r_clk_enable = 1'b1;
        repeat (4) @(negedge r_clk);
        if (regfile_v0 !== final_v0) begin
            $display("FAILED %0t: final regfile_v0 %h, expected %h", $time, regfile_v0, final_v0);
            end_errors = end_errors + 1;
        end
        if (pending_count != 0) begin
            $display("%0d expected write-backs never appeared", pending_count);
            end_errors = end_errors + 1;
        end
        $display("retired %0d of %0d write-backs, %0d checker errors, %0d end-of-run errors",
                 retired_count, write_count, error_count, end_errors);
        if ((error_count == 0) && (end_errors == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // hard stop if write-backs stall
    always @(posedge r_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, write-backs did not all arrive", cycle_count);
            $display("retired %0d of %0d write-backs, %0d checker errors, %0d end-of-run errors",
                     retired_count, write_count, error_count, end_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/rtype_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rtype_props (
    input logic                            r_clk,
    input logic                            reset,
    input logic                            r_clk_enable,
    input logic                            wb_valid,
    input logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    input logic [mips_pkg::xlen-1:0]       wb_data
);

    // sync reset, valid must be low one edge later
    wb_valid_in_reset: assert property (
        @(posedge r_clk) reset |=> !wb_valid
    ) else $error("wb_valid still high after a reset edge");

    // r0 writes are filtered in decode
    wb_reg_not_zero: assert property (
        @(posedge r_clk) disable iff (reset) wb_valid |-> (wb_reg != '0)
    ) else $error("write-back to register 0 marked valid");

    // disabled edge holds all write-back state
    wb_hold_when_disabled: assert property (
        @(posedge r_clk) disable iff (reset)
        !r_clk_enable |=> ($stable(wb_valid) && $stable(wb_reg) && $stable(wb_data))
    ) else $error("write-back outputs moved on a disabled edge");

endmodule

// attach to the selector, names match its ports
bind writeback_select rtype_props u_rtype_props (
    .r_clk, .reset, .r_clk_enable, .wb_valid, .wb_reg, .wb_data
);

`default_nettype wire

/* bench/rtype_vectors.txt */
// instr _ write expected (1/0) _ expected dest reg _ expected data, all hex
// registers start at zero, values built up with nor and shifts
00000827_1_01_ffffffff
00011f02_1_03_0000000f
00032100_1_04_000000f0
00641021_1_02_000000ff
00212820_1_05_fffffffe
00033022_1_06_fffffff1
00643823_1_07_ffffff1f
00a44024_1_08_000000f0
00c34825_1_09_ffffffff
00e15026_1_0a_000000e0
00c3582a_1_0b_00000001
00c3602b_1_0c_00000000
00066903_1_0d_ffffffff
00067102_1_0e_0fffffff
00647804_1_0f_00780000
01068006_1_10_0000ffff
01678807_1_11_ffffff8f
// rd of zero, unsupported funct, non-zero opcode
00210020_0_00_00000000
00039821_1_13_0000000f
00219018_0_00_00000000
8c21a021_0_00_00000000
00129025_1_12_00000000
// v0 rewritten back to back
02641023_1_02_ffffff1f
01621004_1_02_fffffe3e
0040a825_1_15_fffffe3e

/* run.sh */
#!/usr/bin/env bash
# build and run the rtype_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rtype_core_tb -f sources.f

# a failing assertion may stop the run early, the search below decides
sim_out=$(./obj_dir/Vrtype_core_tb || true)
echo "$sim_out"

if grep -qx "TEST PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* sources.f */
src/mips_pkg.sv
src/exec_if.sv
src/regfile.sv
src/issue_stage.sv
src/alu_unit.sv
src/shift_unit.sv
src/writeback_select.sv
src/rtype_core.sv
bench/rtype_props.sv
bench/rtype_checker.sv
bench/rtype_core_tb.sv

/* src/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    exec_if.unit                      ex,
    output logic [mips_pkg::xlen-1:0] alu_result
);
    import mips_pkg::*;

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            lt_signed;
    logic            lt_unsigned;

    // wrapping add and subtract, no overflow trap
    assign sum  = ex.op_a + ex.op_b;
    assign diff = ex.op_a - ex.op_b;

    // comparisons for slt and sltu
    assign lt_signed   = $signed(ex.op_a) < $signed(ex.op_b);
    assign lt_unsigned = ex.op_a < ex.op_b;

    always_comb begin
        case (ex.alu_op)
            op_add: begin
                alu_result = sum;
            end
            op_sub: begin
                alu_result = diff;
            end
            op_and: begin
                alu_result = ex.op_a & ex.op_b;
            end
            op_or: begin
                alu_result = ex.op_a | ex.op_b;
            end
            op_xor: begin
                alu_result = ex.op_a ^ ex.op_b;
            end
            op_nor: begin
                alu_result = ~(ex.op_a | ex.op_b);
            end
            // set-less-than gives 1 or 0
            op_slt: begin
                alu_result = {{(xlen-1){1'b0}}, lt_signed};
            end
            op_sltu: begin
                alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            default: begin
                alu_result = sum;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/exec_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface exec_if;
    import mips_pkg::*;

    // instruction in execute will write back
    logic                  valid;
    // destination register index
    logic [reg_addr_w-1:0] dest;
    // result source for the selector
    exec_unit_e            unit_sel;
    alu_op_e               alu_op;
    shift_op_e             shift_op;
    // forwarded source operands, a = rs, b = rt
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;
    // shamt field, or rs[4:0] for variable shifts
    logic [4:0]            shamt;

    // issue side owns every field
    modport issue (output valid, dest, unit_sel, alu_op, shift_op, op_a, op_b, shamt);
    // execution units only see operands and their op
    modport unit (input op_a, op_b, shamt, alu_op, shift_op);
    // selector needs only control
    modport select (input valid, dest, unit_sel);

endinterface

`default_nettype wire

/* src/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    input  logic                            instr_valid,
    input  logic [31:0]                     instr,
    // register file read ports
    output logic [mips_pkg::reg_addr_w-1:0] read_reg1,
    output logic [mips_pkg::reg_addr_w-1:0] read_reg2,
    input  logic [mips_pkg::xlen-1:0]       read_data1,
    input  logic [mips_pkg::xlen-1:0]       read_data2,
    // result of the instruction now in execute
    input  logic                            exec_fwd_valid,
    input  logic [mips_pkg::reg_addr_w-1:0] exec_fwd_reg,
    input  logic [mips_pkg::xlen-1:0]       exec_fwd_data,
    // result sitting in the write-back register
    input  logic                            wb_valid,
    input  logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    input  logic [mips_pkg::xlen-1:0]       wb_data,
    exec_if.issue                           ex
);
    import mips_pkg::*;

    logic [5:0]            opcode;
    logic [reg_addr_w-1:0] rs, rt, rd;
    logic [4:0]            shamt_field;
    logic [5:0]            funct;
    logic                  supported, var_shift, dec_valid;
    exec_unit_e            dec_unit;
    alu_op_e               dec_alu_op;
    shift_op_e             dec_shift_op;
    logic [xlen-1:0]       src_a, src_b;

    // r-type field split
    assign opcode      = instr[31:26];
    assign rs          = instr[25:21];
    assign rt          = instr[20:16];
    assign rd          = instr[15:11];
    assign shamt_field = instr[10:6];
    assign funct       = instr[5:0];
    assign read_reg1   = rs;
    assign read_reg2   = rt;

    // funct decode
    // unlisted funct codes are unsupported
    always_comb begin
        supported    = 1'b1;
        var_shift    = 1'b0;
        dec_unit     = unit_alu;
        dec_alu_op   = op_add;
        dec_shift_op = op_sll;
        case (funct)
            funct_add, funct_addu: dec_alu_op = op_add;
            funct_sub, funct_subu: dec_alu_op = op_sub;
            funct_and:  dec_alu_op = op_and;
            funct_or:   dec_alu_op = op_or;
            funct_xor:  dec_alu_op = op_xor;
            funct_nor:  dec_alu_op = op_nor;
            funct_slt:  dec_alu_op = op_slt;
            funct_sltu: dec_alu_op = op_sltu;
            funct_sll, funct_sllv: begin
                dec_unit     = unit_shift;
                dec_shift_op = op_sll;
                var_shift    = funct[2];
            end
            funct_srl, funct_srlv: begin
                dec_unit     = unit_shift;
                dec_shift_op = op_srl;
                var_shift    = funct[2];
            end
            funct_sra, funct_srav: begin
                dec_unit     = unit_shift;
                dec_shift_op = op_sra;
                var_shift    = funct[2];
            end
            default: supported = 1'b0;
        endcase
    end

    // non-zero opcode and rd of zero never write back
    assign dec_valid = instr_valid && (opcode == 6'd0) && supported && (rd != '0);

    // newest producer first and register file last
    // r0 never forwards
    function automatic logic [xlen-1:0] pick_operand(
        input logic [reg_addr_w-1:0] src,
        input logic [xlen-1:0]       rf_data
    );
        logic [xlen-1:0] value;
        value = rf_data;
        if (src != '0) begin
            if (exec_fwd_valid && (exec_fwd_reg == src)) begin
                value = exec_fwd_data;
            end else if (wb_valid && (wb_reg == src)) begin
                value = wb_data;
            end
        end
        return value;
    endfunction

    always_comb begin
        src_a = pick_operand(rs, read_data1);
        src_b = pick_operand(rt, read_data2);
    end

    // execute-stage valid
    always_ff @(posedge r_clk) begin
        if (reset) begin
            ex.valid <= 1'b0;
        end else if (r_clk_enable) begin
            ex.valid <= dec_valid;
        end
    end

    // operands and decoded op into execute
    always_ff @(posedge r_clk) begin
        if (r_clk_enable) begin
            ex.dest     <= rd;
            ex.unit_sel <= dec_unit;
            ex.alu_op   <= dec_alu_op;
            ex.shift_op <= dec_shift_op;
            ex.op_a     <= src_a;
            ex.op_b     <= src_b;
            // variable shifts take rs[4:0] as the amount
            ex.shamt    <= var_shift ? src_a[4:0] : shamt_field;
        end
    end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // datapath and register file geometry
    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int reg_addr_w = 5;
    // register shown at the top level (v0)
    localparam int v0_index   = 2;

    // r-type funct field values
    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_srl  = 6'h02;
    localparam logic [5:0] funct_sra  = 6'h03;
    localparam logic [5:0] funct_sllv = 6'h04;
    localparam logic [5:0] funct_srlv = 6'h06;
    localparam logic [5:0] funct_srav = 6'h07;
    localparam logic [5:0] funct_add  = 6'h20;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_sub  = 6'h22;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_nor  = 6'h27;
    localparam logic [5:0] funct_slt  = 6'h2a;
    localparam logic [5:0] funct_sltu = 6'h2b;

    // which unit owns the result
    typedef enum logic [1:0] {
        unit_alu   = 2'd0,
        unit_shift = 2'd1
    } exec_unit_e;

    // alu operations, add and sub never trap
    typedef enum logic [2:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_nor, op_slt, op_sltu
    } alu_op_e;

    // shift operations
    typedef enum logic [1:0] {
        op_sll, op_srl, op_sra
    } shift_op_e;

endpackage

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    // write port, driven from the write-back register
    input  logic                            write_control,
    input  logic [mips_pkg::reg_addr_w-1:0] write_reg,
    input  logic [mips_pkg::xlen-1:0]       write_data,
    // two combinational read ports
    input  logic [mips_pkg::reg_addr_w-1:0] read_reg1,
    input  logic [mips_pkg::reg_addr_w-1:0] read_reg2,
    output logic [mips_pkg::xlen-1:0]       read_data1,
    output logic [mips_pkg::xlen-1:0]       read_data2,
    // live view of v0
    output logic [mips_pkg::xlen-1:0]       regfile_v0
);
    import mips_pkg::*;

    logic [xlen-1:0] registers [0:reg_count-1];

    // whole file clears on reset
    // writes only on enabled edges
    always_ff @(posedge r_clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                registers[i] <= '0;
            end
        end else if (r_clk_enable) begin
            // register 0 writes are dropped
            if (write_control && (write_reg != '0)) begin
                registers[write_reg] <= write_data;
            end
        end
    end

    // register 0 hard-wired to zero
    assign read_data1 = (read_reg1 == '0) ? '0 : registers[read_reg1];
    assign read_data2 = (read_reg2 == '0) ? '0 : registers[read_reg2];

    // v0 tap for the top level
    assign regfile_v0 = registers[v0_index];

endmodule

`default_nettype wire

/* src/rtype_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rtype_core (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    input  logic                            instr_valid,
    input  logic [31:0]                     instr,
    output logic                            wb_valid,
    output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic [mips_pkg::xlen-1:0]       wb_data,
    output logic [mips_pkg::xlen-1:0]       regfile_v0
);
    import mips_pkg::*;

    // register file read path
    logic [reg_addr_w-1:0] read_reg1, read_reg2;
    logic [xlen-1:0]       read_data1, read_data2;
    // forwarding from execute
    logic                  exec_fwd_valid;
    logic [reg_addr_w-1:0] exec_fwd_reg;
    logic [xlen-1:0]       exec_fwd_data;
    // unit results
    logic [xlen-1:0]       alu_result, shift_result;

    // issue to execute bundle
    exec_if ex ();

    issue_stage u_issue_stage (
        .r_clk, .reset, .r_clk_enable,
        .instr_valid, .instr,
        .read_reg1, .read_reg2, .read_data1, .read_data2,
        .exec_fwd_valid, .exec_fwd_reg, .exec_fwd_data,
        .wb_valid, .wb_reg, .wb_data,
        .ex (ex.issue)
    );

    // written from the write-back register, two enabled edges after issue
    regfile u_regfile (
        .r_clk, .reset, .r_clk_enable,
        .write_control (wb_valid),
        .write_reg     (wb_reg),
        .write_data    (wb_data),
        .read_reg1, .read_reg2, .read_data1, .read_data2,
        .regfile_v0
    );

    // both units run on every issued instruction
    alu_unit u_alu_unit (.ex (ex.unit), .alu_result);

    shift_unit u_shift_unit (.ex (ex.unit), .shift_result);

    writeback_select u_writeback_select (
        .r_clk, .reset, .r_clk_enable,
        .ex (ex.select),
        .alu_result, .shift_result,
        .exec_fwd_valid, .exec_fwd_reg, .exec_fwd_data,
        .wb_valid, .wb_reg, .wb_data
    );

endmodule

`default_nettype wire

/* src/shift_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_unit (
    exec_if.unit                      ex,
    output logic [mips_pkg::xlen-1:0] shift_result
);
    import mips_pkg::*;

    logic signed [xlen-1:0] b_signed;

    // sign-aware copy for sra
    assign b_signed = $signed(ex.op_b);

    // op_b is the shifted value (rt)
    // amount already resolved in issue, shamt or rs[4:0]
    always_comb begin
        case (ex.shift_op)
            op_sll: begin
                shift_result = ex.op_b << ex.shamt;
            end
            op_srl: begin
                shift_result = ex.op_b >> ex.shamt;
            end
            // sign bit replicated from the top
            op_sra: begin
                shift_result = $unsigned(b_signed >>> ex.shamt);
            end
            default: begin
                shift_result = ex.op_b;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/writeback_select.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_select (
    input  logic                            r_clk,
    input  logic                            reset,
    input  logic                            r_clk_enable,
    exec_if.select                          ex,
    input  logic [mips_pkg::xlen-1:0]       alu_result,
    input  logic [mips_pkg::xlen-1:0]       shift_result,
    // combinational view of the execute result
    output logic                            exec_fwd_valid,
    output logic [mips_pkg::reg_addr_w-1:0] exec_fwd_reg,
    output logic [mips_pkg::xlen-1:0]       exec_fwd_data,
    // registered write-back, feeds the register file
    output logic                            wb_valid,
    output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic [mips_pkg::xlen-1:0]       wb_data
);
    import mips_pkg::*;

    // result of whichever unit owns this instruction
    always_comb begin
        case (ex.unit_sel)
            unit_shift: exec_fwd_data = shift_result;
            default:    exec_fwd_data = alu_result;
        endcase
    end

    assign exec_fwd_valid = ex.valid;
    assign exec_fwd_reg   = ex.dest;

    // write-back valid, cleared on reset
    always_ff @(posedge r_clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (r_clk_enable) begin
            wb_valid <= exec_fwd_valid;
        end
    end

    // write-back payload, only meaningful with wb_valid
    always_ff @(posedge r_clk) begin
        if (r_clk_enable) begin
            wb_reg  <= exec_fwd_reg;
            wb_data <= exec_fwd_data;
        end
    end

endmodule

`default_nettype wire
